// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = gfx_engine_tb
FILELIST  = sim.f
LOG       = sim.log
PASS_MSG  = Everything OK
RUN_ARGS  = +verilator+error+limit+10

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim.f
source/gfx_pkg.sv
source/bg_fetch.sv
source/sprite_unit.sv
source/pixel_mixer.sv
source/gfx_engine.sv
tests/gfx_engine_asserts.sv
tests/gfx_engine_tb.sv

// File: source/bg_fetch.sv
// Background layer, one VRAM read per visible pixel, data expected one cycle later
// vram_rd_n follows the blanking flags combinationally and is not gated by reset

`timescale 1ns/10ps

module bg_fetch (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  gfx_pkg::coord_t                      coord,
  input  gfx_pkg::reg_write_t                  reg_write,
  output logic [gfx_pkg::vram_addr_width-1:0]  vram_addr,
  output logic                                 vram_rd_n,
  input  gfx_pkg::vram_word_u                  vram_data,
  output gfx_pkg::layer_pixel_t                bg_pixel
);

  logic             gray_mode;  // Control register bit
  logic             gray_mode_d; // Mode seen by the pixel in flight
  logic             x_bit1_d;   // Left or right half of the block
  logic             blank_d;
  logic [7:0]       gray_level;
  gfx_pkg::rgb666_t pix_color;

  // One word per 4x4 block
  assign vram_addr = {coord.y[gfx_pkg::screen_y_width-1:2],
                      coord.x[gfx_pkg::screen_x_width-1:2]};
  assign vram_rd_n = coord.hblank | coord.vblank; // Read only while visible

  // Owns only the gray-mode bit of the control register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gray_mode <= 1'b0;
    end else if (reg_write.wr && reg_write.addr == gfx_pkg::reg_control) begin
      gray_mode <= reg_write.data[gfx_pkg::ctrl_gray_mode];
    end
  end

  // Side info lined up with the word VRAM returns next cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gray_mode_d <= 1'b0;
      x_bit1_d    <= 1'b0;
      blank_d     <= 1'b1;
    end else begin
      gray_mode_d <= gray_mode;
      x_bit1_d    <= coord.x[1];
      blank_d     <= coord.hblank | coord.vblank;
    end
  end

  // Two ways to read the same word
  assign gray_level = x_bit1_d ? vram_data.gray.right_gray : vram_data.gray.left_gray;

  always_comb begin
    if (gray_mode_d) begin
      pix_color.r = gray_level[7:2]; // Top six bits everywhere
      pix_color.g = gray_level[7:2];
      pix_color.b = gray_level[7:2];
    end else begin
      pix_color = gfx_pkg::widen_565(vram_data.rgb);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bg_pixel <= '{opaque: 1'b1, color: '0, blank: 1'b1};
    end else begin
      bg_pixel.opaque <= 1'b1; // Background always covers
      bg_pixel.color  <= pix_color;
      bg_pixel.blank  <= blank_d;
    end
  end

endmodule

// File: source/gfx_engine.sv
// Pixel path top level, fixed 3-cycle latency from coordinate to rgb_out
// Expects a synchronous-read VRAM with one cycle of read latency

`timescale 1ns/10ps

module gfx_engine (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  gfx_pkg::coord_t                      coord,     // From video timing
  input  gfx_pkg::reg_write_t                  reg_write,
  output logic [gfx_pkg::vram_addr_width-1:0]  vram_addr,
  output logic                                 vram_rd_n, // Active low
  input  logic [gfx_pkg::vram_data_width-1:0]  vram_data,
  output gfx_pkg::rgb666_t                     rgb_out
);

  // Layer outputs, both valid after edge 2
  gfx_pkg::layer_pixel_t bg_pixel;
  gfx_pkg::layer_pixel_t sprite_pixel;

  // Background fetch and decode
  bg_fetch bg_fetch_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .coord     (coord),
    .reg_write (reg_write),
    .vram_addr (vram_addr),
    .vram_rd_n (vram_rd_n),
    .vram_data (vram_data), // Same width as the union
    .bg_pixel  (bg_pixel)
  );

  // Sprite runs alongside the fetch
  sprite_unit sprite_unit_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .coord        (coord),
    .reg_write    (reg_write),
    .sprite_pixel (sprite_pixel)
  );

  // Final merge and output register
  pixel_mixer pixel_mixer_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .bg_pixel     (bg_pixel),
    .sprite_pixel (sprite_pixel),
    .rgb_out      (rgb_out)
  );

endmodule

// File: source/gfx_pkg.sv
// Widths, register map and pixel types for the graphics pixel path
// One VRAM word covers a 4x4 screen block, decoded as RGB565 or as two gray bytes
// Register data wider than a field is truncated on write

package gfx_pkg;

  localparam int screen_x_width  = 10;
  localparam int screen_y_width  = 10;
  localparam int vram_addr_width = 16; // {y[9:2], x[9:2]}
  localparam int vram_data_width = 16;
  localparam int reg_addr_width  = 3;
  localparam int reg_data_width  = 16;
  localparam int rgb_depth       = 18;
  localparam int channel_width   = rgb_depth / 3; // 6:6:6

  // Register map
  localparam logic [reg_addr_width-1:0] reg_sprite_x     = 3'd0;
  localparam logic [reg_addr_width-1:0] reg_sprite_y     = 3'd1;
  localparam logic [reg_addr_width-1:0] reg_sprite_w     = 3'd2;
  localparam logic [reg_addr_width-1:0] reg_sprite_h     = 3'd3;
  localparam logic [reg_addr_width-1:0] reg_sprite_color = 3'd4; // RGB565
  localparam logic [reg_addr_width-1:0] reg_control      = 3'd5;

  // Bits of the control register
  localparam int ctrl_sprite_enable = 0;
  localparam int ctrl_gray_mode     = 1;

  // Scan position from the video timing generator
  typedef struct packed {
    logic [screen_x_width-1:0] x;
    logic [screen_y_width-1:0] y;
    logic                      hblank;
    logic                      vblank;
  } coord_t;

  typedef struct packed {
    logic                      wr;   // One-cycle strobe
    logic [reg_addr_width-1:0] addr;
    logic [reg_data_width-1:0] data;
  } reg_write_t;

  typedef struct packed {
    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] b5;
  } rgb565_t;

  typedef struct packed {
    logic [7:0] left_gray;  // Pixels with x[1] == 0
    logic [7:0] right_gray; // Pixels with x[1] == 1
  } gray_pair_t;

  // Same VRAM word, two decodes
  typedef union packed {
    rgb565_t    rgb;
    gray_pair_t gray;
  } vram_word_u;

  typedef struct packed {
    logic [channel_width-1:0] r;
    logic [channel_width-1:0] g;
    logic [channel_width-1:0] b;
  } rgb666_t;

  // Per-layer pixel handed to the mixer
  typedef struct packed {
    logic    opaque;
    rgb666_t color;
    logic    blank;
  } layer_pixel_t;

  // Red and blue get their top bit repeated, green passes
  function automatic rgb666_t widen_565(rgb565_t c);
    rgb666_t w;
    w.r = {c.r5, c.r5[4]};
    w.g = c.g6;
    w.b = {c.b5, c.b5[4]};
    return w;
  endfunction

endpackage

// File: source/pixel_mixer.sv
// Sprite over background with blanking forcing black
// Blank comes from the background side only

`timescale 1ns/10ps

module pixel_mixer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  gfx_pkg::layer_pixel_t bg_pixel,
  input  gfx_pkg::layer_pixel_t sprite_pixel,
  output gfx_pkg::rgb666_t      rgb_out
);

  gfx_pkg::rgb666_t mix_color;

  // Blank first, then sprite, then background
  always_comb begin
    if (bg_pixel.blank) begin
      mix_color = '0;
    end else if (sprite_pixel.opaque) begin
      mix_color = sprite_pixel.color; // Sprite on top
    end else begin
      mix_color = bg_pixel.color;
    end
  end

  // Output register is the third pipeline stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rgb_out <= '0;
    end else begin
      rgb_out <= mix_color;
    end
  end

endmodule

// File: source/sprite_unit.sv
// Single solid-color rectangle with the hit test in two register stages to match bg_fetch
// Zero width or height never hits; rectangle may run past the screen edge

`timescale 1ns/10ps

module sprite_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  gfx_pkg::coord_t       coord,
  input  gfx_pkg::reg_write_t   reg_write,
  output gfx_pkg::layer_pixel_t sprite_pixel
);

  logic [gfx_pkg::screen_x_width-1:0] sprite_x;
  logic [gfx_pkg::screen_y_width-1:0] sprite_y;
  logic [gfx_pkg::screen_x_width-1:0] sprite_w;
  logic [gfx_pkg::screen_y_width-1:0] sprite_h;
  gfx_pkg::rgb565_t                   sprite_color;
  logic                               sprite_en;

  logic [gfx_pkg::screen_x_width:0]   x_end; // One extra bit so the sum never wraps
  logic [gfx_pkg::screen_y_width:0]   y_end;
  logic                               in_x;
  logic                               in_y;
  logic                               hit;

  logic                               hit_1; // Stage 1
  logic                               blank_1;
  gfx_pkg::rgb666_t                   color_1;

  // Sprite side of the register file
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sprite_x     <= '0;
      sprite_y     <= '0;
      sprite_w     <= '0;
      sprite_h     <= '0;
      sprite_color <= '0;
      sprite_en    <= 1'b0;
    end else if (reg_write.wr) begin
      case (reg_write.addr)
        gfx_pkg::reg_sprite_x:     sprite_x     <= reg_write.data[gfx_pkg::screen_x_width-1:0];
        gfx_pkg::reg_sprite_y:     sprite_y     <= reg_write.data[gfx_pkg::screen_y_width-1:0];
        gfx_pkg::reg_sprite_w:     sprite_w     <= reg_write.data[gfx_pkg::screen_x_width-1:0];
        gfx_pkg::reg_sprite_h:     sprite_h     <= reg_write.data[gfx_pkg::screen_y_width-1:0];
        gfx_pkg::reg_sprite_color: sprite_color <= reg_write.data;
        gfx_pkg::reg_control:      sprite_en    <= reg_write.data[gfx_pkg::ctrl_sprite_enable];
        default: ;                 // Not ours
      endcase
    end
  end

  // Half-open ranges [x, x+w) and [y, y+h)
  assign x_end = {1'b0, sprite_x} + {1'b0, sprite_w};
  assign y_end = {1'b0, sprite_y} + {1'b0, sprite_h};
  assign in_x  = (coord.x >= sprite_x) && ({1'b0, coord.x} < x_end);
  assign in_y  = (coord.y >= sprite_y) && ({1'b0, coord.y} < y_end);
  assign hit   = sprite_en && in_x && in_y;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hit_1        <= 1'b0;
      blank_1      <= 1'b1;
      sprite_pixel <= '{opaque: 1'b0, color: '0, blank: 1'b1};
    end else begin
      hit_1              <= hit;
      blank_1            <= coord.hblank | coord.vblank;
      sprite_pixel.opaque <= hit_1; // Extra stage for the VRAM cycle
      sprite_pixel.blank  <= blank_1;
      sprite_pixel.color  <= color_1;
    end
  end

  // Widened color in step with hit_1
  always_ff @(posedge clk) begin
    color_1 <= gfx_pkg::widen_565(sprite_color);
  end

endmodule

// File: tests/gfx_engine_asserts.sv
// Checker bound into gfx_engine, keeps its own register shadow and VRAM fill rule
// Fill rule must match the testbench VRAM model; expected pixel lags coord by 3 edges

`timescale 1ns/10ps

module gfx_engine_asserts (
  input logic                                clk,
  input logic                                rst_n,
  input gfx_pkg::coord_t                     coord,
  input gfx_pkg::reg_write_t                 reg_write,
  input logic [gfx_pkg::vram_addr_width-1:0] vram_addr,
  input logic                                vram_rd_n,
  input gfx_pkg::rgb666_t                    rgb_out
);

  logic [9:0]       sh_x;
  logic [9:0]       sh_y;
  logic [9:0]       sh_w;
  logic [9:0]       sh_h;
  logic [15:0]      sh_color; // RGB565
  logic             sh_en;
  logic             sh_gray;
  gfx_pkg::rgb666_t exp_0;    // Pixel sampled on this edge
  gfx_pkg::rgb666_t exp_1;
  gfx_pkg::rgb666_t exp_2;    // Lines up with rgb_out
  logic             reset_seen;
  int unsigned      fail_count = 0; // Read by the testbench

  // Same fill as the memory model
  function automatic logic [15:0] vram_word(input logic [15:0] addr);
    return addr * 16'h9e37 + 16'h5a3c;
  endfunction

  function automatic gfx_pkg::rgb666_t expected_pixel(input gfx_pkg::coord_t c);
    gfx_pkg::rgb666_t p;
    logic [15:0]      w;
    logic [7:0]       level;
    logic             in_rect;
    in_rect = sh_en && (c.x >= sh_x) && ({1'b0, c.x} < {1'b0, sh_x} + {1'b0, sh_w})
              && (c.y >= sh_y) && ({1'b0, c.y} < {1'b0, sh_y} + {1'b0, sh_h});
    w     = vram_word({c.y[9:2], c.x[9:2]}); // One word per 4x4 block
    level = c.x[1] ? w[7:0] : w[15:8];       // Right half uses low byte
    if (c.hblank || c.vblank) begin
      p = '0;
    end else if (in_rect) begin
      p = '{r: {sh_color[15:11], sh_color[15]}, g: sh_color[10:5], b: {sh_color[4:0], sh_color[4]}};
    end else if (sh_gray) begin
      p = '{r: level[7:2], g: level[7:2], b: level[7:2]};
    end else begin
      p = '{r: {w[15:11], w[15]}, g: w[10:5], b: {w[4:0], w[4]}};
    end
    return p;
  endfunction

  // Register shadow from the write port
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      {sh_x, sh_y, sh_w, sh_h, sh_color, sh_en, sh_gray} <= '0;
    end else if (reg_write.wr) begin
      case (reg_write.addr)
        3'd0: sh_x     <= reg_write.data[9:0];
        3'd1: sh_y     <= reg_write.data[9:0];
        3'd2: sh_w     <= reg_write.data[9:0];
        3'd3: sh_h     <= reg_write.data[9:0];
        3'd4: sh_color <= reg_write.data;
        3'd5: {sh_gray, sh_en} <= reg_write.data[1:0];
        default: ;
      endcase
    end
  end

  // Expected color, computed with the pre-edge shadow
  always_ff @(posedge clk) begin
    reset_seen <= !rst_n;
    if (!rst_n) begin
      exp_0 <= '0;
      exp_1 <= '0;
      exp_2 <= '0;
    end else begin
      exp_0 <= expected_pixel(coord);
      exp_1 <= exp_0;
      exp_2 <= exp_1;
    end
  end

  a_reset_black: assert property (@(posedge clk) reset_seen |-> rgb_out == '0)
    else begin fail_count++; $error("rgb_out not zero after reset"); end

  a_read_enable: assert property (@(posedge clk) vram_rd_n == (coord.hblank || coord.vblank))
    else begin fail_count++; $error("vram_rd_n does not follow blanking"); end

  a_read_addr: assert property (@(posedge clk)
      !vram_rd_n |-> vram_addr == {coord.y[9:2], coord.x[9:2]})
    else begin fail_count++; $error("vram_addr %h wrong", vram_addr); end

  a_pixel: assert property (@(posedge clk) disable iff (!rst_n) rgb_out == exp_2)
    else begin fail_count++; $error("rgb_out %h, expected %h", rgb_out, exp_2); end

endmodule

bind gfx_engine gfx_engine_asserts gfx_engine_asserts_inst (
  .clk       (clk),
  .rst_n     (rst_n),
  .coord     (coord),
  .reg_write (reg_write),
  .vram_addr (vram_addr),
  .vram_rd_n (vram_rd_n),
  .rgb_out   (rgb_out)
);

// File: tests/gfx_engine_tb.sv
// Scans a reduced frame window at a random screen origin per frame
// Pixel checks live in the bound checker; registers change only in leading vblank

`timescale 1ns/10ps

module gfx_engine_tb;

  localparam int          clk_period      = 4;
  localparam int          reset_cycles    = 4;
  localparam int          h_visible       = 32;
  localparam int          h_total         = 40; // 8 hblank columns
  localparam int          v_blank         = 8;  // Leading vblank lines
  localparam int          v_total         = 28;
  localparam int          frames_per_mode = 4;
  localparam int          frame_cycles    = h_total * v_total;
  localparam int          run_cycles      = reset_cycles + 2 * frames_per_mode * frame_cycles + 16;
  localparam logic [31:0] seed            = 32'h01ddfb68;
  localparam logic [15:0] fill_mult       = 16'h9e37;
  localparam logic [15:0] fill_offset     = 16'h5a3c;

  logic                clk = 1'b0;
  logic                rst_n;
  gfx_pkg::coord_t     coord;
  gfx_pkg::reg_write_t reg_write;
  logic [15:0]         vram_addr;
  logic                vram_rd_n;
  logic [15:0]         vram_data = '0;
  gfx_pkg::rgb666_t    rgb_out;
  logic [15:0]         vram_mem [0:65535];

  gfx_engine gfx_engine_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .coord     (coord),
    .reg_write (reg_write),
    .vram_addr (vram_addr),
    .vram_rd_n (vram_rd_n),
    .vram_data (vram_data),
    .rgb_out   (rgb_out)
  );

  always #(clk_period / 2) clk = ~clk;

  // Synchronous read VRAM with one cycle of latency
  always @(posedge clk) begin
    if (!vram_rd_n) vram_data <= vram_mem[vram_addr];
  end

  // One frame; sprite and control written on the second vblank line
  // Shape 1 and 2 give a zero-size sprite, shape 3 turns it off
  task automatic scan_frame(input logic gray, input int shape);
    logic [9:0]  x_org;
    logic [9:0]  y_org;
    logic [15:0] reg_values [0:5]; // Indexed by register address
    x_org = 10'($urandom_range(0, 1023 - h_total));
    y_org = 10'($urandom_range(0, 1023 - v_total));
    // Rectangle reaches into hblank and starts inside vblank
    reg_values[0] = 16'(x_org + 10'($urandom_range(h_visible - 12, h_visible - 2)));
    reg_values[1] = 16'(y_org + 10'($urandom_range(2, v_blank - 1)));
    reg_values[2] = (shape == 1) ? 16'd0 : 16'($urandom_range(14, 24));
    reg_values[3] = (shape == 2) ? 16'd0 : 16'($urandom_range(8, 16));
    reg_values[4] = 16'($urandom());
    reg_values[5] = {14'd0, gray, (shape != 3)};
    for (int row = 0; row < v_total; row++) begin
      for (int col = 0; col < h_total; col++) begin
        @(posedge clk);
        #1;
        coord.x       = x_org + 10'(col);
        coord.y       = y_org + 10'(row);
        coord.hblank  = (col >= h_visible);
        coord.vblank  = (row < v_blank);
        reg_write     = '0;
        if (row == 1 && col < 6) begin
          reg_write.wr   = 1'b1;
          reg_write.addr = 3'(col);
          reg_write.data = reg_values[col];
        end
      end
    end
  endtask

  // First checker failure ends the run
  always @(negedge clk) begin
    if (gfx_engine_inst.gfx_engine_asserts_inst.fail_count != 0) begin
      $display("[ERROR] %0d ns: checker reported a wrong value on the DUT outputs", $time);
      $display("Something failed");
      $fatal(1, "stopped at first checker failure");
    end
  end

  initial begin
    #(run_cycles * clk_period * 2);
    $display("Timeout: scan did not finish within %0d ns", run_cycles * clk_period * 2);
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_n      = 1'b0;
    coord      = '{x: '0, y: '0, hblank: 1'b1, vblank: 1'b1};
    reg_write  = '0;
    void'($urandom(seed));
    for (int a = 0; a < 65536; a++) begin
      vram_mem[a] = 16'(a) * fill_mult + fill_offset; // Depends on every address bit
    end
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int f = 0; f < frames_per_mode; f++) scan_frame(1'b0, f); // RGB565
    for (int f = 0; f < frames_per_mode; f++) scan_frame(1'b1, f); // Gray pairs
    @(posedge clk);
    #1;
    coord.hblank = 1'b1;
    coord.vblank = 1'b1;
    repeat (4) @(posedge clk); // Drain the pipeline
    if (gfx_engine_inst.gfx_engine_asserts_inst.fail_count != 0) begin
      $display("Something failed");
      $fatal(1, "checker failures at end of run");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule
